// ==== Makefile ====
# Verilator simulation of the memory controller testbench

TOP = tb_gba_mem

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f gba_mem.f -o $(TOP)

# Pass only when the log holds the pass message
run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bank_access_if.sv ====
/* Committed bank access */

`timescale 1ns/10ps
`default_nettype none

interface bank_access_if
    import gba_mem_pkg::*;
#(
    parameter int BANK_ADDR_W = 10
) ();

    // Word index on the RAM bus port
    logic [BANK_ADDR_W-1:0] index;
    // Region of the access being presented
    region_t                region;
    logic [DATA_W-1:0]      wdata;
    // Nonzero only in the commit cycle
    logic [BE_W-1:0]        byte_we;

    modport front (
        output index,
        output region,
        output wdata,
        output byte_we
    );

    modport bank (
        input index,
        input region,
        input wdata,
        input byte_we
    );

endinterface : bank_access_if

`default_nettype wire

// ==== bus_front_end.sv ====
/* Bus write latch and byte enables */

`timescale 1ns/10ps
`default_nettype none

module bus_front_end
    import gba_mem_pkg::*;
#(
    parameter int BANK_ADDR_W = 10
) (
    input  logic              clock,
    input  logic              reset,
    input  logic [DATA_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  mem_size_t         size,
    input  logic              write,
    output logic              bus_pause,
    bank_access_if.front      acc
);

    bus_addr_t         addr_live;
    bus_addr_t         addr_q;
    logic [DATA_W-1:0] wdata_q;
    mem_size_t         size_q;
    logic [BE_W-1:0]   byte_sel;

    assign addr_live.word = addr;

    // Access captured every cycle, used one cycle later on a write
    always_ff @(posedge clock) begin
        addr_q.word <= addr;
        wdata_q     <= wdata;
        size_q      <= size;
    end

    // Pause for one cycle per write, the commit happens at its end
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bus_pause <= 1'b0;
        end else begin
            bus_pause <= write & ~bus_pause;
        end
    end

    // Latched address during commit, live address for reads
    always_comb begin
        if (bus_pause) begin
            acc.index  = addr_q.f.offset[BANK_ADDR_W+1:2];
            acc.region = addr_q.f.region;
        end else begin
            acc.index  = addr_live.f.offset[BANK_ADDR_W+1:2];
            acc.region = addr_live.f.region;
        end
    end

    assign acc.wdata = wdata_q;

    // Lanes touched by the latched size and low offset bits
    always_comb begin
        byte_sel = '0;
        case (size_q)
            SIZE_BYTE: begin
                byte_sel[addr_q.f.offset[1:0]] = 1'b1;
            end
            SIZE_HALF: begin
                if (addr_q.f.offset[1]) begin
                    byte_sel = 4'b1100;
                end else begin
                    byte_sel = 4'b0011;
                end
            end
            SIZE_WORD: begin
                byte_sel = 4'b1111;
            end
            default: begin
                byte_sel = '0;
            end
        endcase
    end

    assign acc.byte_we = bus_pause ? byte_sel : '0;

    // A write pauses the bus for exactly one cycle
    pause_single_cycle: assert property (
        @(posedge clock) disable iff (reset)
        bus_pause |=> !bus_pause
    ) else $error("bus_pause held for two cycles");

endmodule : bus_front_end

`default_nettype wire

// ==== gba_mem.f ====
gba_mem_pkg.sv
bank_access_if.sv
bus_front_end.sv
region_bank.sv
read_select.sv
gba_mem.sv
tb_gba_mem.sv

// ==== gba_mem.sv ====
/* Memory controller top */

`timescale 1ns/10ps
`default_nettype none

module gba_mem
    import gba_mem_pkg::*;
#(
    parameter int BANK_ADDR_W = 10
) (
    input  logic                   clock,
    input  logic                   reset,

    // CPU and DMA bus
    input  logic [DATA_W-1:0]      bus_addr,
    input  logic [DATA_W-1:0]      bus_wdata,
    input  mem_size_t              bus_size,
    input  logic                   bus_write,
    output logic [DATA_W-1:0]      bus_rdata,
    output logic                   bus_pause,

    // Graphics read ports, one per region
    input  logic [BANK_ADDR_W-1:0] gfx_addr [NUM_BANKS],
    output logic [DATA_W-1:0]      gfx_data [NUM_BANKS]
);

    bank_access_if #(
        .BANK_ADDR_W(BANK_ADDR_W)
    ) acc ();

    logic [NUM_BANKS-1:0] bank_hit;
    logic [DATA_W-1:0]    bank_rdata [NUM_BANKS];

    bus_front_end #(
        .BANK_ADDR_W(BANK_ADDR_W)
    ) u_front_end (
        .clock     (clock),
        .reset     (reset),
        .addr      (bus_addr),
        .wdata     (bus_wdata),
        .size      (bus_size),
        .write     (bus_write),
        .bus_pause (bus_pause),
        .acc       (acc.front)
    );

    // Internal RAM, palette, VRAM and OAM
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        region_bank #(
            .BANK_ADDR_W (BANK_ADDR_W),
            .REGION      (BANK_REGION[i])
        ) u_bank (
            .clock    (clock),
            .reset    (reset),
            .acc      (acc.bank),
            .gfx_addr (gfx_addr[i]),
            .gfx_data (gfx_data[i]),
            .hit      (bank_hit[i]),
            .rdata    (bank_rdata[i])
        );
    end

    read_select u_read_select (
        .hit        (bank_hit),
        .bank_rdata (bank_rdata),
        .rdata      (bus_rdata)
    );

endmodule : gba_mem

`default_nettype wire

// ==== gba_mem_pkg.sv ====
/* Memory controller shared types */

`default_nettype none

package gba_mem_pkg;

    // Bus data path widths
    localparam int DATA_W = 32;
    localparam int BE_W = 4;
    localparam int BYTE_W = DATA_W / BE_W;

    // Number of RAM regions behind the bus port
    localparam int NUM_BANKS = 4;

    // Region code taken from address bits 31:24
    typedef logic [7:0] region_t;

    // Access size, data is little endian
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    // Decoded view of a bus address
    typedef struct packed {
        region_t     region;
        logic [23:0] offset;
    } addr_fields_t;

    // Flat word as seen on the bus, or region plus offset
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t f;
    } bus_addr_t;

    // Region code served by each bank
    // 0x03 internal RAM, 0x05 palette, 0x06 VRAM, 0x07 OAM
    localparam region_t BANK_REGION [NUM_BANKS] = '{
        8'h03,
        8'h05,
        8'h06,
        8'h07
    };

endpackage : gba_mem_pkg

`default_nettype wire

// ==== read_select.sv ====
/* Bus read data select */

`timescale 1ns/10ps
`default_nettype none

module read_select
    import gba_mem_pkg::*;
(
    input  logic [NUM_BANKS-1:0] hit,
    input  logic [DATA_W-1:0]    bank_rdata [NUM_BANKS],
    output logic [DATA_W-1:0]    rdata
);

    // Unmapped regions read as zero
    always_comb begin
        rdata = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (hit[i]) begin
                rdata = bank_rdata[i];
            end
        end
    end

    // Region codes are distinct, so banks never claim the same read
    always_comb begin
        hit_onehot: assert final ($onehot0(hit))
            else $error("more than one bank hit");
    end

endmodule : read_select

`default_nettype wire

// ==== region_bank.sv ====
/* Dual-port RAM region */

`timescale 1ns/10ps
`default_nettype none

module region_bank
    import gba_mem_pkg::*;
#(
    parameter int      BANK_ADDR_W = 10,
    parameter region_t REGION      = 8'h03
) (
    input  logic                   clock,
    input  logic                   reset,
    bank_access_if.bank            acc,
    input  logic [BANK_ADDR_W-1:0] gfx_addr,
    output logic [DATA_W-1:0]      gfx_data,
    output logic                   hit,
    output logic [DATA_W-1:0]      rdata
);

    localparam int DEPTH = 2 ** BANK_ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];
    logic              region_match;
    logic [BE_W-1:0]   bank_we;

    assign region_match = (acc.region == REGION);

    // Writes to other regions are ignored here
    assign bank_we = region_match ? acc.byte_we : '0;

    // Byte lane writes, old data on both read ports
    always_ff @(posedge clock) begin
        for (int b = 0; b < BE_W; b++) begin
            if (bank_we[b]) begin
                mem[acc.index][b*BYTE_W +: BYTE_W] <= acc.wdata[b*BYTE_W +: BYTE_W];
            end
        end
        rdata    <= mem[acc.index];
        gfx_data <= mem[gfx_addr];
    end

    // Hit follows the bus read by one cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hit <= 1'b0;
        end else begin
            hit <= region_match;
        end
    end

    // Front end must present a known region whenever it commits
    we_region_known: assert property (
        @(posedge clock) disable iff (reset)
        (|acc.byte_we) |-> !$isunknown(acc.region)
    ) else $error("byte write with unknown region");

endmodule : region_bank

`default_nettype wire

// ==== tb_gba_mem.sv ====
/* Memory controller testbench */

`timescale 1ns/10ps
`default_nettype none

module tb_gba_mem
    import gba_mem_pkg::*;
();

    localparam int BANK_ADDR_W = 10;
    localparam int CLK_PERIOD  = 10;
    localparam int SEED        = 57215;
    // Word indices exercised per region, kept small so writes overlap
    localparam int NUM_IDX     = 32;
    localparam int NUM_RANDOM  = 600;
    // Prefill, random mix, mapped sweep and unmapped sweep
    localparam int NUM_OPS     = 2 * NUM_BANKS * NUM_IDX + NUM_IDX + NUM_RANDOM;
    localparam int WATCHDOG_NS = (NUM_OPS * 4 + 20) * CLK_PERIOD;

    // Model key is region code above word index
    typedef logic [8+BANK_ADDR_W-1:0] key_t;

    logic                   clock;
    logic                   reset;
    logic [DATA_W-1:0]      bus_addr;
    logic [DATA_W-1:0]      bus_wdata;
    mem_size_t              bus_size;
    logic                   bus_write;
    logic [DATA_W-1:0]      bus_rdata;
    logic                   bus_pause;
    logic [BANK_ADDR_W-1:0] gfx_addr [NUM_BANKS];
    logic [DATA_W-1:0]      gfx_data [NUM_BANKS];

    logic [DATA_W-1:0]      model [key_t];
    logic                   pend_bus;
    logic [DATA_W-1:0]      pend_bus_exp;
    logic                   pend_gfx;
    int                     pend_gfx_bank;
    logic [DATA_W-1:0]      pend_gfx_exp;

    gba_mem #(
        .BANK_ADDR_W(BANK_ADDR_W)
    ) u_dut (
        .clock     (clock),
        .reset     (reset),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_size  (bus_size),
        .bus_write (bus_write),
        .bus_rdata (bus_rdata),
        .bus_pause (bus_pause),
        .gfx_addr  (gfx_addr),
        .gfx_data  (gfx_data)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t, the test did not complete in time", $time);
        $display("Done: errors found");
        $fatal(1, "watchdog timeout");
    end

    function automatic logic is_mapped(region_t r);
        logic found;
        found = 1'b0;
        for (int k = 0; k < NUM_BANKS; k++) begin
            if (BANK_REGION[k] == r) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Word sets all lanes, half picks by bit 1, byte by bits 1:0
    function automatic logic [BE_W-1:0] lanes_for(mem_size_t s, logic [1:0] low);
        case (s)
            SIZE_WORD: return 4'b1111;
            SIZE_HALF: return low[1] ? 4'b1100 : 4'b0011;
            default:   return 4'b0001 << low;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] merge_lanes(logic [DATA_W-1:0] old_word,
                                                      logic [DATA_W-1:0] new_word,
                                                      logic [BE_W-1:0]   lanes);
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (lanes[b]) begin
                result[b*BYTE_W +: BYTE_W] = new_word[b*BYTE_W +: BYTE_W];
            end
        end
        return result;
    endfunction

    // Unmapped regions read as zero
    function automatic logic [DATA_W-1:0] expected_word(region_t r,
                                                        logic [BANK_ADDR_W-1:0] idx);
        logic [DATA_W-1:0] value;
        key_t              key;
        key = {r, idx};
        value = '0;
        if (is_mapped(r) && model.exists(key)) begin
            value = model[key];
        end
        return value;
    endfunction

    function automatic bus_addr_t make_addr(region_t r, logic [BANK_ADDR_W-1:0] idx,
                                            logic [1:0] low);
        bus_addr_t a;
        a.f.region = r;
        a.f.offset = 24'({idx, low});
        return a;
    endfunction

    // Mostly mapped regions, about one access in eight goes nowhere
    function automatic region_t pick_region();
        region_t r;
        if ($urandom_range(7) == 0) begin
            r = 8'($urandom());
            if (is_mapped(r)) begin
                r = r ^ 8'h80;
            end
        end else begin
            r = BANK_REGION[$urandom_range(NUM_BANKS - 1)];
        end
        return r;
    endfunction

    task automatic check_word(input string name, input logic [DATA_W-1:0] actual,
                              input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Next falling edge, where results of the previous cycle are stable
    task automatic advance_cycle();
        @(negedge clock);
        if (pend_bus) begin
            check_word("bus_rdata", bus_rdata, pend_bus_exp);
        end
        if (pend_gfx) begin
            check_word($sformatf("gfx_data[%0d]", pend_gfx_bank), gfx_data[pend_gfx_bank],
                       pend_gfx_exp);
        end
        pend_bus = 1'b0;
        pend_gfx = 1'b0;
    endtask

    task automatic write_op(input region_t r, input logic [BANK_ADDR_W-1:0] idx,
                            input logic [1:0] low, input mem_size_t s,
                            input logic [DATA_W-1:0] data);
        bus_addr_t a;
        key_t      key;
        a = make_addr(r, idx, low);
        key = {r, idx};
        bus_addr = a.word;
        bus_wdata = data;
        bus_size = s;
        bus_write = 1'b1;
        advance_cycle();
        check_bit("bus_pause", bus_pause, 1'b1);
        // Inputs held through the pause, commit at its closing edge
        advance_cycle();
        check_bit("bus_pause", bus_pause, 1'b0);
        if (is_mapped(r)) begin
            model[key] = merge_lanes(expected_word(r, idx), data, lanes_for(s, low));
        end
        bus_write = 1'b0;
    endtask

    // Bus read and one graphics read in the same cycle
    task automatic read_op(input region_t r, input logic [BANK_ADDR_W-1:0] idx,
                           input logic [1:0] low, input int bank,
                           input logic [BANK_ADDR_W-1:0] gidx);
        bus_addr_t a;
        a = make_addr(r, idx, low);
        bus_addr = a.word;
        bus_size = SIZE_WORD;
        bus_write = 1'b0;
        gfx_addr[bank] = gidx;
        pend_bus = 1'b1;
        pend_bus_exp = expected_word(r, idx);
        pend_gfx = 1'b1;
        pend_gfx_bank = bank;
        pend_gfx_exp = expected_word(BANK_REGION[bank], gidx);
        advance_cycle();
        check_bit("bus_pause", bus_pause, 1'b0);
    endtask

    task automatic random_op();
        region_t                r;
        logic [BANK_ADDR_W-1:0] idx;
        logic [BANK_ADDR_W-1:0] gidx;
        logic [1:0]             low;
        mem_size_t              s;
        int                     bank;
        r = pick_region();
        idx = BANK_ADDR_W'($urandom_range(NUM_IDX - 1));
        low = 2'($urandom_range(3));
        if ($urandom_range(99) < 45) begin
            case ($urandom_range(2))
                0: s = SIZE_BYTE;
                1: s = SIZE_HALF;
                default: s = SIZE_WORD;
            endcase
            write_op(r, idx, low, s, $urandom());
        end else begin
            bank = int'($urandom_range(NUM_BANKS - 1));
            gidx = BANK_ADDR_W'($urandom_range(NUM_IDX - 1));
            read_op(r, idx, low, bank, gidx);
        end
    endtask

    initial begin
        reset = 1'b1;
        bus_addr = '0;
        bus_wdata = '0;
        bus_size = SIZE_WORD;
        bus_write = 1'b0;
        for (int k = 0; k < NUM_BANKS; k++) begin
            gfx_addr[k] = '0;
        end
        pend_bus = 1'b0;
        pend_bus_exp = '0;
        pend_gfx = 1'b0;
        pend_gfx_bank = 0;
        pend_gfx_exp = '0;
        void'($urandom(SEED));

        repeat (2) @(negedge clock);
        reset = 1'b0;

        // Idle after reset, no write has been issued
        advance_cycle();
        check_bit("bus_pause", bus_pause, 1'b0);

        // Known contents for every word in the test window
        for (int k = 0; k < NUM_BANKS; k++) begin
            for (int i = 0; i < NUM_IDX; i++) begin
                write_op(BANK_REGION[k], BANK_ADDR_W'(i), 2'b00, SIZE_WORD, $urandom());
            end
        end

        repeat (NUM_RANDOM) begin
            random_op();
        end

        // Reads on consecutive cycles over every mapped word
        for (int k = 0; k < NUM_BANKS; k++) begin
            for (int i = 0; i < NUM_IDX; i++) begin
                read_op(BANK_REGION[k], BANK_ADDR_W'(i), 2'b00, (k + 1) % NUM_BANKS,
                        BANK_ADDR_W'(NUM_IDX - 1 - i));
            end
        end

        // Region 0x04 sits between mapped regions and must read zero
        for (int i = 0; i < NUM_IDX; i++) begin
            read_op(8'h04, BANK_ADDR_W'(i), 2'b00, i % NUM_BANKS, BANK_ADDR_W'(i));
        end

        $display("Done: no errors");
        $finish;
    end

endmodule : tb_gba_mem

`default_nettype wire
